//--- sources.f
src/decode_pkg.sv
src/inst_decoder.sv
src/operand_bypass.sv
src/branch_resolver.sv
src/decode_stage_ctrl.sv
src/regfile.sv
src/id_stage.sv
sim/tb_clock_gen.sv
sim/id_stage_tb.sv

//--- Makefile
VERILATOR ?= verilator
TOP       ?= id_stage_tb
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert
FAIL_MSG  := *** TEST FAILED ***

SHELL := /bin/bash

.PHONY: all compile run clean

all: run

compile: $(BUILD_DIR)/V$(TOP)

$(BUILD_DIR)/V$(TOP): sources.f $(shell cat sources.f)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(BUILD_DIR) -f sources.f

run: compile
	set -o pipefail; ./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	@if grep -qF '$(FAIL_MSG)' $(LOG); then exit 1; fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)

//--- sim/id_stage_tb.sv
`timescale 1ns/1ps

module id_stage_tb;
    import decode_pkg::*;

    typedef struct packed {
        ds_to_es_t d;
        br_bus_t   b;
    } expect_t;

    logic      clk;
    logic      reset;
    logic      fs_to_ds_valid;
    fs_to_ds_t fs_to_ds;
    logic      ds_allowin;
    logic      ds_to_es_valid;
    ds_to_es_t ds_to_es;
    logic      es_allowin;
    br_bus_t   br_bus;
    es_to_ds_t es_to_ds;
    fwd_src_t  ms_to_ds;
    fwd_src_t  ws_to_ds;
    ws_to_rf_t ws_to_rf;

    logic [XLEN-1:0] shadow [NUM_REGS];
    fs_to_ds_t       held;
    logic [15:0]     lfsr;
    int              errors;
    int              checks;
    string           test_name;

    tb_clock_gen clk_gen (.clk(clk), .reset(reset));

    id_stage DUT (.*);

    // taps 16,14,13,11
    function automatic logic [31:0] rand_bits(input int n);
        logic [31:0] v;
        v = '0;
        for (int i = 0; i < n; i++) begin
            lfsr = {lfsr[14:0], lfsr[15] ^ lfsr[13] ^ lfsr[12] ^ lfsr[10]};
            v = {v[30:0], lfsr[0]};
        end
        return v;
    endfunction

    function automatic logic [31:0] fwd_value(input logic [4:0] a,
            input logic [31:0] regs [NUM_REGS], input es_to_ds_t es,
            input fwd_src_t ms, input fwd_src_t ws);
        if (a == '0) return '0;
        if (es.fwd.valid && es.fwd.gr_we && es.fwd.dest == a) return es.fwd.data;
        if (ms.valid && ms.gr_we && ms.dest == a) return ms.data;
        if (ws.valid && ws.gr_we && ws.dest == a) return ws.data;
        return regs[a];
    endfunction

    function automatic expect_t ref_model(input logic [31:0] w, input logic [31:0] pc,
            input logic [31:0] regs [NUM_REGS], input es_to_ds_t es,
            input fwd_src_t ms, input fwd_src_t ws);
        expect_t     e;
        int          a;
        logic        store;
        logic        cond;
        logic        use_imm;
        logic        met;
        logic        jirl;
        logic [4:0]  r2;
        logic [31:0] rjv;
        logic [31:0] rkv;
        logic [31:0] offs;
        e = '0;
        a = -1;
        store = 1'b0;
        cond = 1'b0;
        use_imm = 1'b0;
        met = 1'b0;
        jirl = 1'b0;
        e.d.ctrl.dest = w[4:0];
        offs = {{14{w[25]}}, w[25:10], 2'b0};
        case (w[31:15])
            17'h00020: a = ALU_ADD;
            17'h00022: a = ALU_SUB;
            17'h00024: a = ALU_SLT;
            17'h00025: a = ALU_SLTU;
            17'h00028: a = ALU_NOR;
            17'h00029: a = ALU_AND;
            17'h0002a: a = ALU_OR;
            17'h0002b: a = ALU_XOR;
            17'h00081: a = ALU_SLL;
            17'h00089: a = ALU_SRL;
            17'h00091: a = ALU_SRA;
            default: ;
        endcase
        if (a >= ALU_SLL) begin
            e.d.ctrl.imm = {27'b0, w[14:10]};
            use_imm = 1'b1;
        end
        case (w[31:22])
            10'h008: a = ALU_SLT;
            10'h009: a = ALU_SLTU;
            10'h00a: a = ALU_ADD;
            10'h00d: a = ALU_AND;
            10'h00e: a = ALU_OR;
            10'h00f: a = ALU_XOR;
            10'h0a2: a = ALU_ADD;
            10'h0a6: a = ALU_ADD;
            default: ;
        endcase
        if (w[31:22] inside {10'h008, 10'h009, 10'h00a, 10'h0a2, 10'h0a6}) begin
            e.d.ctrl.imm = {{20{w[21]}}, w[21:10]};
            use_imm = 1'b1;
        end else if (w[31:22] inside {10'h00d, 10'h00e, 10'h00f}) begin
            e.d.ctrl.imm = {20'b0, w[21:10]};
            use_imm = 1'b1;
        end
        e.d.ctrl.res_from_mem = w[31:22] == 10'h0a2;
        store = w[31:22] == 10'h0a6;
        if (w[31:25] == 7'h0a || w[31:25] == 7'h0e) begin
            a = (w[31:25] == 7'h0a) ? ALU_LUI : ALU_ADD;
            e.d.ctrl.src1_is_pc = w[31:25] == 7'h0e;
            e.d.ctrl.imm = {w[24:5], 12'b0};
            use_imm = 1'b1;
        end
        case (w[31:26])
            6'h13: jirl = 1'b1;
            6'h15: e.d.ctrl.dest = 5'd1;
            default: cond = w[31:26] inside {[6'h16:6'h1b]};
        endcase
        if (w[31:26] == 6'h13 || w[31:26] == 6'h15) begin
            a = ALU_ADD;
            e.d.ctrl.src1_is_pc = 1'b1;
            e.d.ctrl.imm = 32'd4;
            use_imm = 1'b1;
        end
        if (w[31:26] == 6'h14 || w[31:26] == 6'h15) begin
            offs = {{4{w[9]}}, w[9:0], w[25:10], 2'b0};
        end
        if (a >= 0) e.d.ctrl.alu_op[a] = 1'b1;
        e.d.ctrl.src2_is_imm = use_imm;
        e.d.ctrl.mem_we = store;
        e.d.ctrl.gr_we = (a >= 0) && !store;
        r2 = (store || cond) ? w[4:0] : w[14:10];
        rjv = fwd_value(w[9:5], regs, es, ms, ws);
        rkv = fwd_value(r2, regs, es, ms, ws);
        e.d.rj_value = rjv;
        e.d.rkd_value = rkv;
        e.d.pc = pc;
        case (w[31:26])
            6'h16: met = rjv == rkv;
            6'h17: met = rjv != rkv;
            6'h18: met = $signed(rjv) < $signed(rkv);
            6'h19: met = $signed(rjv) >= $signed(rkv);
            6'h1a: met = rjv < rkv;
            6'h1b: met = rjv >= rkv;
            default: met = w[31:26] inside {6'h13, 6'h14, 6'h15};
        endcase
        e.b.taken = met;
        e.b.target = jirl ? rjv + offs : pc + offs;
        return e;
    endfunction

    function automatic logic [31:0] rand_alu_inst();
        logic [4:0]  rd;
        logic [4:0]  rj;
        logic [4:0]  rk;
        logic [11:0] i12;
        rd = 5'(rand_bits(5));
        rj = 5'(rand_bits(5));
        rk = 5'(rand_bits(5));
        i12 = 12'(rand_bits(12));
        case (rand_bits(5))
            0: return {17'h00022, rk, rj, rd};
            1: return {17'h00024, rk, rj, rd};
            2: return {17'h00025, rk, rj, rd};
            3: return {17'h00028, rk, rj, rd};
            4: return {17'h00029, rk, rj, rd};
            5: return {17'h0002a, rk, rj, rd};
            6: return {17'h0002b, rk, rj, rd};
            7: return {17'h00081, rk, rj, rd};
            8: return {17'h00089, rk, rj, rd};
            9: return {17'h00091, rk, rj, rd};
            10: return {10'h008, i12, rj, rd};
            11: return {10'h009, i12, rj, rd};
            12: return {10'h00a, i12, rj, rd};
            13: return {10'h00d, i12, rj, rd};
            14: return {10'h00e, i12, rj, rd};
            15: return {10'h00f, i12, rj, rd};
            16: return {10'h0a2, i12, rj, rd};
            17: return {10'h0a6, i12, rj, rd};
            18: return {7'h0a, i12, rk, rj[2:0], rd};
            19: return {7'h0e, i12, rk, rj[2:0], rd};
            default: return {17'h00020, rk, rj, rd};
        endcase
    endfunction

    function automatic fwd_src_t rand_src(input logic [4:0] a, input logic [4:0] b);
        fwd_src_t s;
        s.valid = rand_bits(1) != 0;
        s.gr_we = rand_bits(2) != 0;
        case (rand_bits(2))
            0: s.dest = a;
            1: s.dest = b;
            2: s.dest = '0;
            default: s.dest = 5'(rand_bits(5));
        endcase
        s.data = rand_bits(32);
        return s;
    endfunction

    task automatic write_reg(input logic [4:0] a, input logic [31:0] d);
        @(negedge clk);
        ws_to_rf = '{we: 1'b1, waddr: a, wdata: d};
        @(negedge clk);
        ws_to_rf.we = 1'b0;
    endtask

    task automatic wait_accept();
        int t;
        t = 0;
        do begin
            @(posedge clk);
            t++;
        end while (!ds_allowin && t < 50);
        if (!ds_allowin) begin
            errors++;
            $display("%s: decode stage never accepted the instruction", test_name);
        end
        @(negedge clk);
        fs_to_ds_valid = 1'b0;
    endtask

    task automatic send(input logic [31:0] w, input logic [31:0] pc);
        @(negedge clk);
        fs_to_ds_valid = 1'b1;
        fs_to_ds = {w, pc};
        wait_accept();
    endtask

    task automatic wait_issue();
        int t;
        t = 0;
        do begin
            @(posedge clk);
            t++;
        end while (!(ds_to_es_valid && es_allowin) && t < 50);
        if (!(ds_to_es_valid && es_allowin)) begin
            errors++;
            $display("%s: instruction never issued to execute", test_name);
        end
    endtask

    // compare against the reference, then track the held word and registers
    always @(posedge clk) begin
        expect_t e;
        if (!reset && ds_to_es_valid) begin
            e = ref_model(held.inst, held.pc, shadow, es_to_ds, ms_to_ds, ws_to_ds);
            checks++;
            if (ds_to_es !== e.d) begin
                errors++;
                $display("CHECK FAILED %s ds_to_es exp=%h act=%h", test_name, e.d, ds_to_es);
            end
            if (br_bus !== e.b) begin
                errors++;
                $display("CHECK FAILED %s br_bus exp=%h act=%h", test_name, e.b, br_bus);
            end
        end
        if (!reset && fs_to_ds_valid && ds_allowin) held = fs_to_ds;
        if (ws_to_rf.we && ws_to_rf.waddr != '0) shadow[ws_to_rf.waddr] = ws_to_rf.wdata;
    end

    initial begin
        logic [4:0]  rj;
        logic [4:0]  rk;
        logic [31:0] w;
        ds_to_es_t   snap;
        int          t;
        fs_to_ds_valid = 1'b0;
        fs_to_ds = '0;
        es_allowin = 1'b1;
        es_to_ds = '0;
        ms_to_ds = '0;
        ws_to_ds = '0;
        ws_to_rf = '0;
        lfsr = 16'd45475;
        errors = 0;
        checks = 0;
        test_name = "reset";
        for (int i = 0; i < NUM_REGS; i++) shadow[i] = '0;
        t = 0;
        while (reset && t < 100) begin
            @(posedge clk);
            t++;
        end
        if (reset) begin
            errors++;
            $display("reset was never released");
        end
        @(negedge clk);
        if (ds_to_es_valid !== 1'b0 || br_bus.taken !== 1'b0 || ds_allowin !== 1'b1) begin
            errors++;
            $display("CHECK FAILED %s valid/taken/allowin exp=001 act=%b%b%b", test_name,
                     ds_to_es_valid, br_bus.taken, ds_allowin);
        end

        for (int a = 1; a < NUM_REGS; a++) write_reg(5'(a), rand_bits(32));

        test_name = "decode";
        repeat (40) begin
            send(rand_alu_inst(), {30'(rand_bits(30)), 2'b0});
            wait_issue();
        end

        test_name = "forward";
        repeat (40) begin
            rj = (rand_bits(2) == 0) ? 5'd0 : 5'(rand_bits(5));
            rk = 5'(rand_bits(5));
            @(negedge clk);
            es_to_ds = '{fwd: rand_src(rj, rk), is_ld: 1'b0};
            ms_to_ds = rand_src(rj, rk);
            ws_to_ds = rand_src(rj, rk);
            send({17'h00020, rk, rj, 5'(rand_bits(5))}, {30'(rand_bits(30)), 2'b0});
            wait_issue();
        end

        test_name = "load_use";
        for (int n = 0; n < 8; n++) begin
            rj = 5'(rand_bits(5)) | 5'd1;
            // odd rounds use jirl so a stalled jump must not redirect
            if (n % 2 == 1) begin
                w = {6'h13, 16'(rand_bits(16)), rj, 5'(rand_bits(5))};
            end else begin
                w = {17'h00020, 5'(rand_bits(5)), rj, 5'(rand_bits(5))};
            end
            @(negedge clk);
            es_to_ds = '{fwd: '{1'b1, 1'b1, rj, rand_bits(32)}, is_ld: 1'b1};
            send(w, 32'h1000);
            repeat (3) begin
                @(posedge clk);
                if (ds_to_es_valid || br_bus.taken || ds_allowin) begin
                    errors++;
                    $display("CHECK FAILED %s valid/taken/allowin exp=000 act=%b%b%b",
                             test_name, ds_to_es_valid, br_bus.taken, ds_allowin);
                end
            end
            @(negedge clk);
            es_to_ds.is_ld = 1'b0;
            wait_issue();
        end
        @(negedge clk);
        es_to_ds = '0;
        ms_to_ds = '0;
        ws_to_ds = '0;

        test_name = "branch";
        repeat (40) begin
            rj = 5'(rand_bits(5));
            rk = (rand_bits(2) == 0) ? rj : 5'(rand_bits(5));
            send({6'(6'h13 + rand_bits(4) % 9), 16'(rand_bits(16)), rj, rk},
                 {30'(rand_bits(30)), 2'b0});
            wait_issue();
        end

        test_name = "backpressure";
        @(negedge clk);
        es_allowin = 1'b0;
        send(rand_alu_inst(), 32'h2000);
        // next instruction waits at the fetch side
        fs_to_ds_valid = 1'b1;
        fs_to_ds = {rand_alu_inst(), 32'h2004};
        @(posedge clk);
        snap = ds_to_es;
        repeat (4) begin
            @(posedge clk);
            if (ds_to_es !== snap || ds_allowin) begin
                errors++;
                $display("CHECK FAILED %s hold exp=%h act=%h allowin=%b", test_name,
                         snap, ds_to_es, ds_allowin);
            end
        end
        @(negedge clk);
        es_allowin = 1'b1;
        wait_accept();
        wait_issue();

        repeat (2) @(negedge clk);
        $display("checks: %0d  errors: %0d", checks, errors);
        if (errors == 0) begin
            $display("*** TEST PASSED ***");
        end else begin
            $display("*** TEST FAILED ***");
        end
        $finish;
    end

endmodule

//--- sim/tb_clock_gen.sv
`timescale 1ns/1ps

module tb_clock_gen (
    output logic clk,
    output logic reset
);
    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    initial begin
        reset = 1'b1;
        repeat (16) @(posedge clk);
        reset <= 1'b0;
    end
endmodule

//--- src/id_stage.sv
`timescale 1ns/1ps

module id_stage (
    input  logic                  clk,
    input  logic                  reset,
    input  logic                  fs_to_ds_valid,
    input  decode_pkg::fs_to_ds_t fs_to_ds,
    output logic                  ds_allowin,
    output logic                  ds_to_es_valid,
    output decode_pkg::ds_to_es_t ds_to_es,
    input  logic                  es_allowin,
    output decode_pkg::br_bus_t   br_bus,
    input  decode_pkg::es_to_ds_t es_to_ds,
    input  decode_pkg::fwd_src_t  ms_to_ds,
    input  decode_pkg::fwd_src_t  ws_to_ds,
    input  decode_pkg::ws_to_rf_t ws_to_rf
);
    import decode_pkg::*;

    fs_to_ds_t                                 ds_inst;
    decode_ctrl_t                              ctrl;
    br_ctrl_t                                  br;
    logic                                      ds_go;
    logic [NUM_READ_PORTS-1:0]                 hit_es;
    logic [NUM_READ_PORTS-1:0][REG_ADDR_W-1:0] raddr;
    logic [NUM_READ_PORTS-1:0][XLEN-1:0]       rf_rdata;
    logic [NUM_READ_PORTS-1:0][XLEN-1:0]       opnd;

    decode_stage_ctrl u_ctrl (
        .clk            (clk),
        .reset          (reset),
        .fs_to_ds_valid (fs_to_ds_valid),
        .fs_to_ds       (fs_to_ds),
        .es_allowin     (es_allowin),
        .es_is_ld       (es_to_ds.is_ld),
        .hit_es         (hit_es),
        .ds_allowin     (ds_allowin),
        .ds_go          (ds_go),
        .ds_valid       (),
        .ds_inst        (ds_inst)
    );

    inst_decoder u_dec (
        .ds_inst (ds_inst),
        .ctrl    (ctrl),
        .br      (br),
        .raddr   (raddr)
    );

    regfile u_rf (
        .clk   (clk),
        .raddr (raddr),
        .wr    (ws_to_rf),
        .rdata (rf_rdata)
    );

    // one bypass per read port
    for (genvar i = 0; i < NUM_READ_PORTS; i++) begin : g_port
        operand_bypass u_bypass (
            .raddr    (raddr[i]),
            .rf_rdata (rf_rdata[i]),
            .es       (es_to_ds),
            .ms       (ms_to_ds),
            .ws       (ws_to_ds),
            .value    (opnd[i]),
            .hit_es   (hit_es[i])
        );
    end

    branch_resolver u_br (
        .br        (br),
        .rj_value  (opnd[0]),
        .rkd_value (opnd[1]),
        .pc        (ds_inst.pc),
        .ds_go     (ds_go),
        .br_bus    (br_bus)
    );

    assign ds_to_es_valid = ds_go;
    assign ds_to_es = '{ctrl: ctrl, rj_value: opnd[0], rkd_value: opnd[1], pc: ds_inst.pc};

endmodule

//--- src/regfile.sv
`timescale 1ns/1ps

module regfile (
    input  logic                         clk,
    input  logic [decode_pkg::NUM_READ_PORTS-1:0][decode_pkg::REG_ADDR_W-1:0] raddr,
    input  decode_pkg::ws_to_rf_t        wr,
    output logic [decode_pkg::NUM_READ_PORTS-1:0][decode_pkg::XLEN-1:0] rdata
);
    import decode_pkg::*;

    logic [XLEN-1:0] rf [NUM_REGS];

    always_ff @(posedge clk) begin
        if (wr.we && (wr.waddr != '0)) begin
            rf[wr.waddr] <= wr.wdata;
        end
    end

    // asynchronous read ports
    always_comb begin
        for (int i = 0; i < NUM_READ_PORTS; i++) begin
            rdata[i] = (raddr[i] == '0) ? '0 : rf[raddr[i]];
        end
    end

endmodule

//--- src/decode_stage_ctrl.sv
`timescale 1ns/1ps

module decode_stage_ctrl (
    input  logic                                  clk,
    input  logic                                  reset,
    input  logic                                  fs_to_ds_valid,
    input  decode_pkg::fs_to_ds_t                 fs_to_ds,
    input  logic                                  es_allowin,
    input  logic                                  es_is_ld,
    input  logic [decode_pkg::NUM_READ_PORTS-1:0] hit_es,
    output logic                                  ds_allowin,
    output logic                                  ds_go,
    output logic                                  ds_valid,
    output decode_pkg::fs_to_ds_t                 ds_inst
);
    logic load_use;
    logic ready_go;

    // load data is not ready until the memory stage
    assign load_use   = es_is_ld && (|hit_es);
    assign ready_go   = !load_use;
    assign ds_go      = ds_valid && ready_go;
    assign ds_allowin = !ds_valid || (ready_go && es_allowin);

    always_ff @(posedge clk) begin
        if (reset) begin
            ds_valid <= 1'b0;
        end else if (ds_allowin) begin
            ds_valid <= fs_to_ds_valid;
        end
    end

    always_ff @(posedge clk) begin
        if (fs_to_ds_valid && ds_allowin) begin
            ds_inst <= fs_to_ds;
        end
    end

    a_valid_known: assert property (@(posedge clk) disable iff (reset)
        !$isunknown(ds_valid));

endmodule

//--- src/branch_resolver.sv
`timescale 1ns/1ps

module branch_resolver (
    input  decode_pkg::br_ctrl_t        br,
    input  logic [decode_pkg::XLEN-1:0] rj_value,
    input  logic [decode_pkg::XLEN-1:0] rkd_value,
    input  logic [decode_pkg::XLEN-1:0] pc,
    input  logic                        ds_go,
    output decode_pkg::br_bus_t         br_bus
);
    logic eq;
    logic lt_s;
    logic lt_u;
    logic cond_met;

    assign eq   = rj_value == rkd_value;
    assign lt_s = $signed(rj_value) < $signed(rkd_value);
    assign lt_u = rj_value < rkd_value;

    assign cond_met = (br.beq  &&  eq)
                   || (br.bne  && !eq)
                   || (br.blt  &&  lt_s)
                   || (br.bge  && !lt_s)
                   || (br.bltu &&  lt_u)
                   || (br.bgeu && !lt_u);

    always_comb begin
        // a stalled branch must not redirect fetch
        br_bus.taken  = ds_go && (br.uncond || cond_met);
        // jirl is register relative, the rest pc relative
        br_bus.target = br.is_jirl ? rj_value + br.offs : pc + br.offs;
    end

endmodule

//--- src/operand_bypass.sv
`timescale 1ns/1ps

module operand_bypass (
    input  logic [decode_pkg::REG_ADDR_W-1:0] raddr,
    input  logic [decode_pkg::XLEN-1:0]       rf_rdata,
    input  decode_pkg::es_to_ds_t             es,
    input  decode_pkg::fwd_src_t              ms,
    input  decode_pkg::fwd_src_t              ws,
    output logic [decode_pkg::XLEN-1:0]       value,
    output logic                              hit_es
);
    logic nonzero;
    logic hit_ms;
    logic hit_ws;

    // r0 is hardwired, never forward it
    assign nonzero = |raddr;

    assign hit_es = nonzero && es.fwd.valid && es.fwd.gr_we
                 && (es.fwd.dest == raddr);
    assign hit_ms = nonzero && ms.valid && ms.gr_we
                 && (ms.dest == raddr);
    assign hit_ws = nonzero && ws.valid && ws.gr_we
                 && (ws.dest == raddr);

    // youngest producer wins
    assign value = hit_es ? es.fwd.data :
                   hit_ms ? ms.data :
                   hit_ws ? ws.data : rf_rdata;

    always_comb begin
        if (!nonzero) begin
            a_r0_no_fwd: assert final (value == '0);
        end
    end

endmodule

//--- src/inst_decoder.sv
`timescale 1ns/1ps

module inst_decoder (
    input  decode_pkg::fs_to_ds_t    ds_inst,
    output decode_pkg::decode_ctrl_t ctrl,
    output decode_pkg::br_ctrl_t     br,
    output logic [decode_pkg::NUM_READ_PORTS-1:0][decode_pkg::REG_ADDR_W-1:0] raddr
);
    import decode_pkg::*;

    inst_u inst;
    logic  inst_add_w, inst_sub_w, inst_slt, inst_sltu;
    logic  inst_and, inst_or, inst_nor, inst_xor;
    logic  inst_slli_w, inst_srli_w, inst_srai_w;
    logic  inst_addi_w, inst_slti, inst_sltui, inst_andi, inst_ori, inst_xori;
    logic  inst_lu12i_w, inst_pcaddu12i, inst_ld_w, inst_st_w;
    logic  inst_beq, inst_bne, inst_blt, inst_bge, inst_bltu, inst_bgeu;
    logic  inst_b, inst_bl, inst_jirl;
    logic  need_ui5, need_si12, need_ui12, need_si20, src2_is_4;
    logic  cond_br;
    logic  inst_known;

    assign inst = ds_inst.inst;

    // 3R and shift-immediate ops
    assign inst_add_w  = inst.r3.opcode == 17'h00020;
    assign inst_sub_w  = inst.r3.opcode == 17'h00022;
    assign inst_slt    = inst.r3.opcode == 17'h00024;
    assign inst_sltu   = inst.r3.opcode == 17'h00025;
    assign inst_nor    = inst.r3.opcode == 17'h00028;
    assign inst_and    = inst.r3.opcode == 17'h00029;
    assign inst_or     = inst.r3.opcode == 17'h0002a;
    assign inst_xor    = inst.r3.opcode == 17'h0002b;
    assign inst_slli_w = inst.r3.opcode == 17'h00081;
    assign inst_srli_w = inst.r3.opcode == 17'h00089;
    assign inst_srai_w = inst.r3.opcode == 17'h00091;

    assign inst_slti   = inst.ri12.opcode == 10'h008;
    assign inst_sltui  = inst.ri12.opcode == 10'h009;
    assign inst_addi_w = inst.ri12.opcode == 10'h00a;
    assign inst_andi   = inst.ri12.opcode == 10'h00d;
    assign inst_ori    = inst.ri12.opcode == 10'h00e;
    assign inst_xori   = inst.ri12.opcode == 10'h00f;
    assign inst_ld_w   = inst.ri12.opcode == 10'h0a2;
    assign inst_st_w   = inst.ri12.opcode == 10'h0a6;

    assign inst_lu12i_w   = inst.ri20.opcode == 7'h0a;
    assign inst_pcaddu12i = inst.ri20.opcode == 7'h0e;

    assign inst_jirl = inst.ri16.opcode == 6'h13;
    assign inst_b    = inst.i26.opcode == 6'h14;
    assign inst_bl   = inst.i26.opcode == 6'h15;
    assign inst_beq  = inst.ri16.opcode == 6'h16;
    assign inst_bne  = inst.ri16.opcode == 6'h17;
    assign inst_blt  = inst.ri16.opcode == 6'h18;
    assign inst_bge  = inst.ri16.opcode == 6'h19;
    assign inst_bltu = inst.ri16.opcode == 6'h1a;
    assign inst_bgeu = inst.ri16.opcode == 6'h1b;

    assign cond_br   = inst_beq | inst_bne | inst_blt | inst_bge | inst_bltu | inst_bgeu;
    assign need_ui5  = inst_slli_w | inst_srli_w | inst_srai_w;
    assign need_si12 = inst_addi_w | inst_ld_w | inst_st_w | inst_slti | inst_sltui;
    assign need_ui12 = inst_andi | inst_ori | inst_xori;
    assign need_si20 = inst_lu12i_w | inst_pcaddu12i;
    assign src2_is_4 = inst_jirl | inst_bl;

    // anything else leaves every control low
    assign inst_known = inst_add_w | inst_sub_w | inst_slt | inst_sltu | inst_nor
                      | inst_and | inst_or | inst_xor | need_ui5 | need_si12 | need_ui12
                      | need_si20 | src2_is_4 | inst_b | cond_br;

    always_comb begin
        ctrl.alu_op           = '0;
        ctrl.alu_op[ALU_ADD]  = inst_add_w | inst_addi_w | inst_ld_w | inst_st_w
                              | inst_jirl | inst_bl | inst_pcaddu12i;
        ctrl.alu_op[ALU_SUB]  = inst_sub_w;
        ctrl.alu_op[ALU_SLT]  = inst_slt | inst_slti;
        ctrl.alu_op[ALU_SLTU] = inst_sltu | inst_sltui;
        ctrl.alu_op[ALU_AND]  = inst_and | inst_andi;
        ctrl.alu_op[ALU_NOR]  = inst_nor;
        ctrl.alu_op[ALU_OR]   = inst_or | inst_ori;
        ctrl.alu_op[ALU_XOR]  = inst_xor | inst_xori;
        ctrl.alu_op[ALU_SLL]  = inst_slli_w;
        ctrl.alu_op[ALU_SRL]  = inst_srli_w;
        ctrl.alu_op[ALU_SRA]  = inst_srai_w;
        ctrl.alu_op[ALU_LUI]  = inst_lu12i_w;
        ctrl.src1_is_pc   = inst_jirl | inst_bl | inst_pcaddu12i;
        ctrl.src2_is_imm  = need_ui5 | need_si12 | need_ui12 | need_si20 | src2_is_4;
        ctrl.res_from_mem = inst_ld_w;
        ctrl.mem_we       = inst_st_w;
        ctrl.gr_we        = inst_known & ~(inst_st_w | inst_b | cond_br);
        ctrl.dest         = inst_bl ? REG_ADDR_W'(1) : inst.r3.rd;
        // link value is pc + 4
        ctrl.imm = src2_is_4 ? XLEN'(4) :
                   need_si20 ? {inst.ri20.i20, 12'b0} :
                   need_si12 ? {{20{inst.ri12.i12[11]}}, inst.ri12.i12} :
                   need_ui12 ? {20'b0, inst.ri12.i12} :
                   need_ui5  ? {27'b0, inst.r3.rk} : '0;
    end

    always_comb begin
        br.beq     = inst_beq;
        br.bne     = inst_bne;
        br.blt     = inst_blt;
        br.bge     = inst_bge;
        br.bltu    = inst_bltu;
        br.bgeu    = inst_bgeu;
        br.uncond  = inst_b | inst_bl | inst_jirl;
        br.is_jirl = inst_jirl;
        br.offs    = (inst_b | inst_bl) ?
                     {{4{inst.i26.offs_hi[9]}}, inst.i26.offs_hi, inst.i26.offs_lo, 2'b0} :
                     {{14{inst.ri16.i16[15]}}, inst.ri16.i16, 2'b0};
    end

    // stores and compares read rd on the second port
    assign raddr[0] = inst.r3.rj;
    assign raddr[1] = (inst_st_w | cond_br) ? inst.r3.rd : inst.r3.rk;

endmodule

//--- src/decode_pkg.sv
package decode_pkg;

    localparam int XLEN           = 32;
    localparam int REG_ADDR_W     = 5;
    localparam int NUM_REGS       = 32;
    localparam int NUM_READ_PORTS = 2;
    localparam int ALU_OP_W       = 12;

    // bit positions in the one-hot alu_op
    localparam int ALU_ADD  = 0;
    localparam int ALU_SUB  = 1;
    localparam int ALU_SLT  = 2;
    localparam int ALU_SLTU = 3;
    localparam int ALU_AND  = 4;
    localparam int ALU_NOR  = 5;
    localparam int ALU_OR   = 6;
    localparam int ALU_XOR  = 7;
    localparam int ALU_SLL  = 8;
    localparam int ALU_SRL  = 9;
    localparam int ALU_SRA  = 10;
    localparam int ALU_LUI  = 11;

    typedef struct packed {
        logic [16:0]           opcode;
        logic [REG_ADDR_W-1:0] rk;
        logic [REG_ADDR_W-1:0] rj;
        logic [REG_ADDR_W-1:0] rd;
    } r3_fmt_t;

    typedef struct packed {
        logic [9:0]            opcode;
        logic [11:0]           i12;
        logic [REG_ADDR_W-1:0] rj;
        logic [REG_ADDR_W-1:0] rd;
    } ri12_fmt_t;

    typedef struct packed {
        logic [5:0]            opcode;
        logic [15:0]           i16;
        logic [REG_ADDR_W-1:0] rj;
        logic [REG_ADDR_W-1:0] rd;
    } ri16_fmt_t;

    typedef struct packed {
        logic [6:0]            opcode;
        logic [19:0]           i20;
        logic [REG_ADDR_W-1:0] rd;
    } ri20_fmt_t;

    // the 26-bit offset is split, high part sits in the low bits
    typedef struct packed {
        logic [5:0]  opcode;
        logic [15:0] offs_lo;
        logic [9:0]  offs_hi;
    } i26_fmt_t;

    typedef union packed {
        r3_fmt_t   r3;
        ri12_fmt_t ri12;
        ri16_fmt_t ri16;
        ri20_fmt_t ri20;
        i26_fmt_t  i26;
    } inst_u;

    typedef struct packed {
        inst_u           inst;
        logic [XLEN-1:0] pc;
    } fs_to_ds_t;

    typedef struct packed {
        logic                  we;
        logic [REG_ADDR_W-1:0] waddr;
        logic [XLEN-1:0]       wdata;
    } ws_to_rf_t;

    typedef struct packed {
        logic                  valid;
        logic                  gr_we;
        logic [REG_ADDR_W-1:0] dest;
        logic [XLEN-1:0]       data;
    } fwd_src_t;

    typedef struct packed {
        fwd_src_t fwd;
        logic     is_ld;
    } es_to_ds_t;

    typedef struct packed {
        logic [ALU_OP_W-1:0]   alu_op;
        logic                  src1_is_pc;
        logic                  src2_is_imm;
        logic                  res_from_mem;
        logic                  gr_we;
        logic                  mem_we;
        logic [REG_ADDR_W-1:0] dest;
        logic [XLEN-1:0]       imm;
    } decode_ctrl_t;

    typedef struct packed {
        logic            beq;
        logic            bne;
        logic            blt;
        logic            bge;
        logic            bltu;
        logic            bgeu;
        logic            uncond;
        logic            is_jirl;
        logic [XLEN-1:0] offs;
    } br_ctrl_t;

    typedef struct packed {
        decode_ctrl_t    ctrl;
        logic [XLEN-1:0] rj_value;
        logic [XLEN-1:0] rkd_value;
        logic [XLEN-1:0] pc;
    } ds_to_es_t;

    typedef struct packed {
        logic            taken;
        logic [XLEN-1:0] target;
    } br_bus_t;

endpackage
